/* design/qla_params.svh */
// QLA motor-current path constants
// channel count, register map, DAC framing and safety limits

`ifndef QLA_PARAMS_SVH
`define QLA_PARAMS_SVH

// ----------------------------------------
// register map
`define QLA_NUM_CHAN        4           // axes 1..4
`define QLA_ADDR_W          8           // [7:4] channel, [3:0] offset
`define QLA_OFF_DAC_CTRL    4'd0        // per axis, commanded current, r/w
`define QLA_OFF_ADC_DATA    4'd1        // per axis, latest feedback, ro
`define QLA_OFF_STATUS      4'd0        // global, {dac_busy, amp_disable}
`define QLA_OFF_AMP_EN      4'd1        // global, set bits clear disables
`define QLA_OFF_DAC_UPD     4'd2        // global, any write starts a pass

// ----------------------------------------
// DAC serial frame
`define QLA_DAC_FRAME_BITS  24
`define QLA_DAC_CMD         4'b0011     // write and update
`define QLA_SCLK_HALF       2           // sysclk cycles per sclk half period

// ----------------------------------------
// safety limits, offset binary currents
`define QLA_CUR_MID         16'h8000    // zero current
`define QLA_SAFETY_MARGIN   16'h0100    // slack above 2x command
`define QLA_SAFETY_COUNT    4           // consecutive bad samples to trip

`endif

/* design/qla_pkg.sv */
// Shared types of the QLA motor-current path
// currents, channel masks, DAC frames, Wishbone words and DAC FSM states

`default_nettype none

`include "qla_params.svh"

package qla_pkg;

    // offset binary, midscale is zero current
    typedef logic [15:0] cur_t;

    // one bit per axis, bit 0 is axis 1
    typedef logic [`QLA_NUM_CHAN-1:0] chan_mask_t;

    // axis number minus one
    typedef logic [1:0] chan_idx_t;

    // one DAC transfer, sent MSB first
    typedef struct packed {
        logic [3:0] cmd;    // command nibble
        logic [3:0] addr;   // DAC channel, zero-extended axis index
        cur_t       value;  // commanded current
    } dac_frame_t;

    // host bus words
    typedef logic [31:0]            wb_data_t;
    typedef logic [`QLA_ADDR_W-1:0] wb_addr_t;

    // DAC sequencer states
    typedef enum logic [1:0] {
        DAC_IDLE,   // waiting for an update request
        DAC_LOAD,   // frame for current axis goes into the shifter
        DAC_SHIFT,  // csel low, 24 sclk periods
        DAC_GAP     // csel high between frames
    } dac_state_t;

endpackage

`default_nettype wire

/* design/dac_bit_timer.sv */
// DAC serial clock timer
// divides sysclk into sclk while run is high, ticks on each falling
// sclk edge and flags the tick that ends the frame

`default_nettype none

`include "qla_params.svh"

module dac_bit_timer import qla_pkg::*; (
    input  wire logic sysclk,
    input  wire logic arst_n,
    input  wire logic run,          // clears both counters when low
    output logic      sclk,
    output logic      shift_tick,   // one per sclk period, at the fall
    output logic      frame_done    // with the last tick
);

    localparam int FRAME_BITS = $bits(dac_frame_t);
    localparam int HALF       = `QLA_SCLK_HALF;
    localparam int HCNT_W     = (HALF > 1) ? $clog2(HALF) : 1;
    localparam int BCNT_W     = $clog2(FRAME_BITS);

    logic [HCNT_W-1:0] hcnt;        // sysclk cycles within half period
    logic [BCNT_W-1:0] bcnt;        // bits sent, 0..23
    logic              half_end;

    assign half_end   = run && (hcnt == HCNT_W'(HALF - 1));
    assign shift_tick = half_end && sclk;              // sclk about to fall
    assign frame_done = shift_tick && (bcnt == BCNT_W'(FRAME_BITS - 1));

    // ----------------------------------------
    // counters, idle low
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            hcnt <= '0;
            bcnt <= '0;
            sclk <= 1'b0;
        end else if (!run) begin
            hcnt <= '0;
            bcnt <= '0;
            sclk <= 1'b0;
        end else begin
            hcnt <= half_end ? '0 : hcnt + 1'b1;
            if (half_end)
                sclk <= ~sclk;
            if (shift_tick)
                bcnt <= frame_done ? '0 : bcnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* design/dac_shifter.sv */
// DAC frame shift register
// assembles command, axis and commanded current on load,
// then shifts left on each falling sclk with mosi taken from the MSB

`default_nettype none

`include "qla_params.svh"

module dac_shifter import qla_pkg::*; (
    input  wire logic      sysclk,
    input  wire logic      arst_n,
    input  wire logic      load,        // from sequencer, DAC_LOAD
    input  wire logic      shift_tick,  // from timer, falling sclk
    input  wire chan_idx_t chan,
    input  wire cur_t      cur_cmd [`QLA_NUM_CHAN],
    output logic           mosi
);

    dac_frame_t frame_q;
    dac_frame_t frame_new;

    // next frame, current sampled at load
    always_comb begin
        frame_new.cmd   = `QLA_DAC_CMD;
        frame_new.addr  = 4'(chan);
        frame_new.value = cur_cmd[chan];
    end

    // ----------------------------------------
    // shift register, zeros shifted in
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            frame_q <= '0;                     // mosi low out of reset
        end else if (load) begin
            frame_q <= frame_new;
        end else if (shift_tick) begin
            frame_q <= {frame_q[`QLA_DAC_FRAME_BITS-2:0], 1'b0};
        end
    end

    assign mosi = frame_q[`QLA_DAC_FRAME_BITS-1];     // bit 23 first

endmodule

`default_nettype wire

/* design/dac_sequencer.sv */
// DAC pass sequencer
// walks axes 1..4 on each update request, one 24-bit frame per axis,
// with a load cycle before and a csel-high gap between frames

`default_nettype none

`include "qla_params.svh"

module dac_sequencer import qla_pkg::*; (
    input  wire logic sysclk,
    input  wire logic arst_n,
    input  wire logic dac_req,      // pending update, level
    input  wire logic frame_done,   // 24th falling sclk
    output logic      dac_busy,
    output logic      run,          // timer enable
    output logic      load,         // shifter load strobe
    output logic      csel,         // DAC chip select, active low
    output chan_idx_t chan          // axis being sent
);

    localparam chan_idx_t LAST_CHAN = chan_idx_t'(`QLA_NUM_CHAN - 1);

    dac_state_t state;

    // decoded from state
    assign dac_busy = (state != DAC_IDLE);     // whole pass
    assign run      = (state == DAC_SHIFT);
    assign load     = (state == DAC_LOAD);

    // ----------------------------------------
    // pass FSM
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            state <= DAC_IDLE;
            chan  <= '0;
            csel  <= 1'b1;
        end else begin
            case (state)
                DAC_IDLE: begin
                    if (dac_req) begin
                        state <= DAC_LOAD;
                        chan  <= '0;           // axis 1 first
                    end
                end
                DAC_LOAD: begin
                    state <= DAC_SHIFT;
                    csel  <= 1'b0;             // frame opens with bit 23 on mosi
                end
                DAC_SHIFT: begin
                    if (frame_done) begin
                        csel <= 1'b1;
                        // last axis ends the pass
                        if (chan == LAST_CHAN)
                            state <= DAC_IDLE;
                        else
                            state <= DAC_GAP;
                    end
                end
                DAC_GAP: begin
                    chan  <= chan + 2'd1;      // next axis
                    state <= DAC_LOAD;
                end
                default: state <= DAC_IDLE;
            endcase
        end
    end

    // chip select never left low once the pass is over
    assert property (@(posedge sysclk) disable iff (!arst_n) (state == DAC_IDLE) |-> csel);

endmodule

`default_nettype wire

/* design/safety_check.sv */
// Per-axis overcurrent check
// trips when feedback magnitude exceeds twice the command magnitude plus
// a margin for several consecutive samples, held until cleared

`default_nettype none

`include "qla_params.svh"

module safety_check import qla_pkg::*; (
    input  wire logic sysclk,
    input  wire logic arst_n,
    input  wire logic adc_valid,    // new feedback sample
    input  wire logic clear,        // from AMP_EN write
    input  wire cur_t cur_fb,
    input  wire cur_t cur_cmd,
    output logic      amp_disable
);

    localparam int COUNT = `QLA_SAFETY_COUNT;
    localparam int CNT_W = $clog2(COUNT + 1);

    logic [17:0]      fb_mag;       // |fb - mid|
    logic [17:0]      cmd_mag;      // |cmd - mid|
    logic [17:0]      bound;
    logic             viol;
    logic [CNT_W-1:0] cnt;          // consecutive violations

    // distances from midscale, 18 bits leaves room for 2x plus margin
    assign fb_mag  = (cur_fb >= `QLA_CUR_MID) ? 18'(cur_fb - `QLA_CUR_MID)
                                              : 18'(`QLA_CUR_MID - cur_fb);
    assign cmd_mag = (cur_cmd >= `QLA_CUR_MID) ? 18'(cur_cmd - `QLA_CUR_MID)
                                               : 18'(`QLA_CUR_MID - cur_cmd);
    assign bound   = (cmd_mag << 1) + 18'(`QLA_SAFETY_MARGIN);
    assign viol    = (fb_mag > bound);

    // ----------------------------------------
    // persistence and latch, clear wins
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            cnt         <= '0;
            amp_disable <= 1'b0;
        end else if (clear) begin
            cnt         <= '0;
            amp_disable <= 1'b0;
        end else if (adc_valid) begin
            if (!viol) begin
                cnt <= '0;                     // run broken
            end else begin
                if (cnt != CNT_W'(COUNT))
                    cnt <= cnt + 1'b1;         // saturates
                if (cnt == CNT_W'(COUNT - 1))
                    amp_disable <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* design/qla_reg_bus.sv */
// Host register bus for the QLA motor-current path
// Wishbone classic slave with single-cycle ack, holds the commanded currents,
// the pending DAC update request and the amplifier-enable clear pulse,
// and returns commands, feedback and global status on reads

`default_nettype none

`include "qla_params.svh"

module qla_reg_bus import qla_pkg::*; (
    input  wire logic     sysclk,
    input  wire logic     arst_n,
    // Wishbone classic slave
    input  wire logic     wb_cyc,
    input  wire logic     wb_stb,
    input  wire logic     wb_we,
    input  wire wb_addr_t wb_adr,
    input  wire wb_data_t wb_wdata,
    output wb_data_t      wb_rdata,
    output logic          wb_ack,
    // motor-current path
    input  wire cur_t     cur_fb [`QLA_NUM_CHAN],
    input  wire chan_mask_t amp_disable,
    input  wire logic     dac_busy,
    output cur_t          cur_cmd [`QLA_NUM_CHAN],
    output chan_mask_t    amp_clear,
    output logic          dac_req
);

    // ----------------------------------------
    // address decode
    logic [3:0] adr_chan;       // 0 is global
    logic [3:0] adr_off;
    logic       is_global;
    logic       axis_ok;        // channel 1..QLA_NUM_CHAN
    chan_idx_t  axis;
    logic       acc;            // new access this cycle
    logic       wr;
    logic       busy_q;         // for dac_busy rise
    wb_data_t   rd_mux;

    assign adr_chan  = wb_adr[7:4];
    assign adr_off   = wb_adr[3:0];
    assign is_global = (adr_chan == 4'd0);
    assign axis_ok   = !is_global && (adr_chan <= 4'(`QLA_NUM_CHAN));
    assign axis      = chan_idx_t'(adr_chan - 4'd1);
    assign acc       = wb_cyc && wb_stb && !wb_ack;    // ack blocks back-to-back
    assign wr        = acc && wb_we;

    // readback mux, unmapped reads as zero
    always_comb begin
        rd_mux = '0;
        if (is_global) begin
            if (adr_off == `QLA_OFF_STATUS)
                rd_mux = wb_data_t'({dac_busy, amp_disable});   // busy lands in bit 4
        end else if (axis_ok) begin
            case (adr_off)
                `QLA_OFF_DAC_CTRL: rd_mux = wb_data_t'(cur_cmd[axis]);
                `QLA_OFF_ADC_DATA: rd_mux = wb_data_t'(cur_fb[axis]);
                default:           rd_mux = '0;
            endcase
        end
    end

    // ----------------------------------------
    // ack, write side, update request
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            wb_ack    <= 1'b0;
            amp_clear <= '0;
            dac_req   <= 1'b0;
            busy_q    <= 1'b0;
            for (int i = 0; i < `QLA_NUM_CHAN; i++) begin
                cur_cmd[i] <= `QLA_CUR_MID;    // zero current
            end
        end else begin
            wb_ack    <= acc;
            busy_q    <= dac_busy;
            amp_clear <= '0;                   // one-cycle pulse
            if (wr && axis_ok && adr_off == `QLA_OFF_DAC_CTRL)
                cur_cmd[axis] <= wb_wdata[15:0];
            if (wr && is_global && adr_off == `QLA_OFF_AMP_EN)
                amp_clear <= wb_wdata[`QLA_NUM_CHAN-1:0];
            // pending pass, writes during a pass coalesce
            if (wr && is_global && adr_off == `QLA_OFF_DAC_UPD)
                dac_req <= 1'b1;
            else if (dac_busy && !busy_q)
                dac_req <= 1'b0;               // sequencer took it
        end
    end

    // read data travels with ack
    always_ff @(posedge sysclk) begin
        if (acc)
            wb_rdata <= rd_mux;
    end

    // master holding stb after ack must not get a second ack
    assert property (@(posedge sysclk) disable iff (!arst_n) wb_ack |=> !wb_ack);

endmodule

`default_nettype wire

/* design/qla_motor_top.sv */
// QLA motor-current command path, top level
// host register bus, DAC pass sequencer with bit timer and shifter,
// and one overcurrent check per axis

`default_nettype none

`include "qla_params.svh"

module qla_motor_top import qla_pkg::*; (
    input  wire logic     sysclk,
    input  wire logic     arst_n,
    // host Wishbone
    input  wire logic     wb_cyc,
    input  wire logic     wb_stb,
    input  wire logic     wb_we,
    input  wire wb_addr_t wb_adr,
    input  wire wb_data_t wb_wdata,
    output wb_data_t      wb_rdata,
    output logic          wb_ack,
    // ADC feedback, parallel samples
    input  wire logic     adc_valid,
    input  wire cur_t     cur_fb [`QLA_NUM_CHAN],
    // DAC and amplifiers
    output logic          dac_sclk,
    output logic          dac_mosi,
    output logic          dac_csel,
    output chan_mask_t    amp_disable
);

    cur_t       cur_cmd [`QLA_NUM_CHAN];  // commanded currents
    chan_mask_t amp_clear;
    logic       dac_req;
    logic       dac_busy;
    logic       run;
    logic       load;
    logic       shift_tick;
    logic       frame_done;
    chan_idx_t  chan;

    // ----------------------------------------
    // register bus
    qla_reg_bus reg_bus_i (
        .sysclk(sysclk), .arst_n(arst_n),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_wdata(wb_wdata), .wb_rdata(wb_rdata), .wb_ack(wb_ack),
        .cur_fb(cur_fb), .amp_disable(amp_disable), .dac_busy(dac_busy),
        .cur_cmd(cur_cmd), .amp_clear(amp_clear), .dac_req(dac_req)
    );

    // ----------------------------------------
    // DAC path
    dac_sequencer dac_seq_i (
        .sysclk(sysclk), .arst_n(arst_n), .dac_req(dac_req), .frame_done(frame_done),
        .dac_busy(dac_busy), .run(run), .load(load), .csel(dac_csel), .chan(chan)
    );

    dac_bit_timer dac_timer_i (
        .sysclk(sysclk), .arst_n(arst_n), .run(run),
        .sclk(dac_sclk), .shift_tick(shift_tick), .frame_done(frame_done)
    );

    dac_shifter dac_shift_i (
        .sysclk(sysclk), .arst_n(arst_n), .load(load), .shift_tick(shift_tick),
        .chan(chan), .cur_cmd(cur_cmd), .mosi(dac_mosi)
    );

    // ----------------------------------------
    // safety, one per axis
    for (genvar i = 0; i < `QLA_NUM_CHAN; i++) begin : g_safe
        safety_check safe_i (
            .sysclk(sysclk), .arst_n(arst_n), .adc_valid(adc_valid),
            .clear(amp_clear[i]), .cur_fb(cur_fb[i]), .cur_cmd(cur_cmd[i]),
            .amp_disable(amp_disable[i])
        );
    end

endmodule

`default_nettype wire

/* bench/qla_motor_tb.sv */
// Testbench for the QLA motor-current path
// table-driven Wishbone accesses, ADC samples and DAC passes,
// DAC frames captured from the serial pins, watchdog on total run time

`default_nettype none

`include "qla_params.svh"

module qla_motor_tb import qla_pkg::*; ();

    localparam int CLK_PERIOD   = 100;
    localparam int DRIVE_DLY    = 10;     // inputs change after the rising edge
    localparam int ACK_LIMIT    = 16;     // cycles to wait for wb_ack
    localparam int FRAME_CYCLES = 130;    // budget per DAC frame

    typedef enum logic [1:0] {OP_WR, OP_RD, OP_ADC, OP_DAC} op_t;

    // for OP_ADC the adr column holds the axis number, for OP_DAC dat is the pass count
    typedef struct {
        op_t      op;
        wb_addr_t adr;
        wb_data_t dat;
        wb_data_t exp;
    } entry_t;

    logic       sysclk;
    logic       arst_n;
    logic       wb_cyc;
    logic       wb_stb;
    logic       wb_we;
    wb_addr_t   wb_adr;
    wb_data_t   wb_wdata;
    wb_data_t   wb_rdata;
    logic       wb_ack;
    logic       adc_valid;
    cur_t       fb_drv [`QLA_NUM_CHAN];
    logic       dac_sclk;
    logic       dac_mosi;
    logic       dac_csel;
    chan_mask_t amp_disable;

    entry_t     tbl [$];
    dac_frame_t frames [$];               // from the frame monitor
    int         frame_bits [$];           // sclk rises per frame
    cur_t       cmd_model [`QLA_NUM_CHAN];    // expected DAC_CTRL contents
    int         seed = 87714;
    int         err_count = 0;
    int         check_count = 0;
    bit         table_ready = 1'b0;

    qla_motor_top qla_motor_top_i (
        .sysclk(sysclk), .arst_n(arst_n),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_wdata(wb_wdata), .wb_rdata(wb_rdata), .wb_ack(wb_ack),
        .adc_valid(adc_valid), .cur_fb(fb_drv),
        .dac_sclk(dac_sclk), .dac_mosi(dac_mosi), .dac_csel(dac_csel),
        .amp_disable(amp_disable)
    );

    initial begin
        sysclk = 1'b0;
        forever #(CLK_PERIOD / 2) sysclk = ~sysclk;
    end

    // ----------------------------------------
    // compare tasks
    task automatic check_word(input string name, input wb_data_t exp, input wb_data_t act);
        check_count++;
        if (act !== exp) begin
            err_count++;
            $display("ERROR at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_frame(input string name, input dac_frame_t exp, input dac_frame_t act);
        check_count++;
        if (act !== exp) begin
            err_count++;
            $display("ERROR at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_mask(input string name, input chan_mask_t exp, input chan_mask_t act);
        check_count++;
        if (act !== exp) begin
            err_count++;
            $display("ERROR at %0t: %s expected %b, got %b", $time, name, exp, act);
        end
    endtask

    task automatic report_fail(input string msg);
        err_count++;
        $display("error at %0t: %s", $time, msg);
    endtask

    // ----------------------------------------
    // stimulus tasks
    function automatic wb_addr_t reg_adr(input int chan, input logic [3:0] off);
        return {4'(chan), off};           // channel 0 is global space
    endfunction

    task automatic add_entry(input op_t op, input wb_addr_t adr, input wb_data_t dat,
                             input wb_data_t exp);
        entry_t e;
        e.op  = op;
        e.adr = adr;
        e.dat = dat;
        e.exp = exp;
        tbl.push_back(e);
    endtask

    // one classic cycle, master holds until ack
    task automatic bus_cycle(input logic we, input wb_addr_t adr, input wb_data_t wdata,
                             output wb_data_t rdata, output bit acked);
        int waited;
        @(posedge sysclk);
        #DRIVE_DLY;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_wdata = wdata;
        waited   = 0;
        acked    = 1'b0;
        rdata    = '0;
        while (!acked && waited < ACK_LIMIT) begin
            @(negedge sysclk);            // ack and data settled mid-cycle
            if (wb_ack === 1'b1) begin
                acked = 1'b1;
                rdata = wb_rdata;
            end
            waited++;
        end
        @(posedge sysclk);
        #DRIVE_DLY;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        if (!acked)
            report_fail($sformatf("no Wishbone ack for address %h", adr));
    endtask

    // one valid strobe, value held afterwards for readback
    task automatic adc_sample(input int chan, input cur_t value);
        @(posedge sysclk);
        #DRIVE_DLY;
        fb_drv[chan-1] = value;
        adc_valid      = 1'b1;
        @(posedge sysclk);
        #DRIVE_DLY;
        adc_valid = 1'b0;
        @(negedge sysclk);
    endtask

    // wait for passes*4 frames, then compare against the command model
    task automatic dac_passes(input int passes);
        int         want;
        int         waited;
        int         nbits;
        dac_frame_t exp_frame;
        dac_frame_t got;
        want   = passes * `QLA_NUM_CHAN;
        waited = 0;
        while (frames.size() < want && waited < want * FRAME_CYCLES) begin
            @(negedge sysclk);
            waited++;
        end
        if (frames.size() < want)
            report_fail($sformatf("missing DAC frame, %0d of %0d seen", frames.size(), want));
        repeat (20) @(negedge sysclk);    // a further pass would open csel by now
        if (frames.size() > want || dac_csel !== 1'b1)
            report_fail("DAC started another pass after the expected ones");
        for (int i = 0; i < want && frames.size() > 0; i++) begin
            exp_frame.cmd   = `QLA_DAC_CMD;
            exp_frame.addr  = 4'(i % `QLA_NUM_CHAN);     // axis order 1..4
            exp_frame.value = cmd_model[i % `QLA_NUM_CHAN];
            got   = frames.pop_front();
            nbits = frame_bits.pop_front();
            check_frame("dac_mosi frame", exp_frame, got);
            if (nbits != `QLA_DAC_FRAME_BITS)
                report_fail($sformatf("frame %0d had %0d sclk pulses with csel low", i, nbits));
        end
        frames.delete();
        frame_bits.delete();
    endtask

    // ----------------------------------------
    // frame monitor
    initial begin : frame_monitor
        dac_frame_t word;
        int         nbits;
        forever begin
            @(negedge dac_csel);
            word  = '0;
            nbits = 0;
            while (dac_csel === 1'b0) begin
                @(posedge dac_sclk or posedge dac_csel);
                if (dac_csel === 1'b0) begin
                    word = {word[`QLA_DAC_FRAME_BITS-2:0], dac_mosi};   // MSB first
                    nbits++;
                end
            end
            frames.push_back(word);
            frame_bits.push_back(nbits);
        end
    end

    // ----------------------------------------
    // stimulus table
    task automatic build_table();
        cur_t rnd [`QLA_NUM_CHAN];
        // reset values and readback
        add_entry(OP_RD, reg_adr(0, `QLA_OFF_STATUS), '0, '0);
        for (int ch = 1; ch <= `QLA_NUM_CHAN; ch++)
            add_entry(OP_RD, reg_adr(ch, `QLA_OFF_DAC_CTRL), '0, 32'h8000);
        for (int ch = 1; ch <= `QLA_NUM_CHAN; ch++) begin
            rnd[ch-1] = cur_t'($random(seed));
            add_entry(OP_WR, reg_adr(ch, `QLA_OFF_DAC_CTRL), wb_data_t'(rnd[ch-1]), '0);
        end
        for (int ch = 1; ch <= `QLA_NUM_CHAN; ch++)
            add_entry(OP_RD, reg_adr(ch, `QLA_OFF_DAC_CTRL), '0, wb_data_t'(rnd[ch-1]));
        add_entry(OP_WR, reg_adr(0, `QLA_OFF_DAC_CTRL), 32'h0000_1234, '0);  // status, ro
        for (int ch = 1; ch <= `QLA_NUM_CHAN; ch++)
            add_entry(OP_RD, reg_adr(ch, `QLA_OFF_DAC_CTRL), '0, wb_data_t'(rnd[ch-1]));
        add_entry(OP_RD, 8'h53, '0, '0);                           // unmapped
        // one pass
        add_entry(OP_WR, reg_adr(0, `QLA_OFF_DAC_UPD), 32'd1, '0);
        add_entry(OP_DAC, '0, 32'd1, '0);
        // two writes during a pass coalesce into one more
        add_entry(OP_WR, reg_adr(0, `QLA_OFF_DAC_UPD), 32'd1, '0);
        add_entry(OP_RD, reg_adr(0, `QLA_OFF_STATUS), '0, 32'h10);     // busy bit
        add_entry(OP_WR, reg_adr(0, `QLA_OFF_DAC_UPD), 32'd1, '0);
        add_entry(OP_WR, reg_adr(0, `QLA_OFF_DAC_UPD), 32'd1, '0);
        add_entry(OP_DAC, '0, 32'd2, '0);
        add_entry(OP_RD, reg_adr(0, `QLA_OFF_STATUS), '0, '0);
        // axis 1 at zero command, bound is the margin alone
        add_entry(OP_WR, reg_adr(1, `QLA_OFF_DAC_CTRL), 32'h8000, '0);
        for (int n = 0; n < `QLA_SAFETY_COUNT - 1; n++)
            add_entry(OP_ADC, 8'd1, 32'h8200, '0);
        add_entry(OP_ADC, 8'd1, 32'h8000, '0);                     // run broken
        for (int n = 0; n < `QLA_SAFETY_COUNT - 1; n++)
            add_entry(OP_ADC, 8'd1, 32'h7E00, '0);
        add_entry(OP_ADC, 8'd1, 32'h7E00, 32'h1);                  // trips
        add_entry(OP_RD, reg_adr(0, `QLA_OFF_STATUS), '0, 32'h1);
        // feedback on the other axes stays inside their bounds
        add_entry(OP_ADC, 8'd2, 32'h8010, 32'h1);
        add_entry(OP_ADC, 8'd3, 32'h7FF0, 32'h1);
        add_entry(OP_ADC, 8'd4, 32'h8055, 32'h1);
        add_entry(OP_RD, reg_adr(1, `QLA_OFF_ADC_DATA), '0, 32'h7E00);
        add_entry(OP_RD, reg_adr(2, `QLA_OFF_ADC_DATA), '0, 32'h8010);
        add_entry(OP_RD, reg_adr(3, `QLA_OFF_ADC_DATA), '0, 32'h7FF0);
        add_entry(OP_RD, reg_adr(4, `QLA_OFF_ADC_DATA), '0, 32'h8055);
        // clear through AMP_EN
        add_entry(OP_WR, reg_adr(0, `QLA_OFF_AMP_EN), 32'h1, '0);
        add_entry(OP_RD, reg_adr(0, `QLA_OFF_STATUS), '0, '0);
        add_entry(OP_ADC, 8'd1, 32'h8000, '0);
        add_entry(OP_RD, reg_adr(1, `QLA_OFF_ADC_DATA), '0, 32'h8000);
    endtask

    // ----------------------------------------
    // main sequence
    initial begin : run_tests
        wb_data_t rdata;
        bit       acked;
        int       errs_before;
        entry_t   e;
        arst_n    = 1'b0;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = '0;
        wb_wdata  = '0;
        adc_valid = 1'b0;
        for (int ch = 0; ch < `QLA_NUM_CHAN; ch++) begin
            fb_drv[ch]    = `QLA_CUR_MID;
            cmd_model[ch] = `QLA_CUR_MID;   // commands reset to zero current
        end
        build_table();
        table_ready = 1'b1;
        repeat (2) @(posedge sysclk);
        #DRIVE_DLY;
        arst_n = 1'b1;

        for (int idx = 0; idx < tbl.size(); idx++) begin
            e           = tbl[idx];
            errs_before = err_count;
            case (e.op)
                OP_WR: begin
                    bus_cycle(1'b1, e.adr, e.dat, rdata, acked);
                    // track per-axis DAC_CTRL writes
                    if (acked && e.adr[3:0] == `QLA_OFF_DAC_CTRL && e.adr[7:4] != 4'd0
                            && e.adr[7:4] <= 4'(`QLA_NUM_CHAN))
                        cmd_model[e.adr[7:4] - 4'd1] = e.dat[15:0];
                end
                OP_RD: begin
                    bus_cycle(1'b0, e.adr, '0, rdata, acked);
                    if (acked)
                        check_word("wb_rdata", e.exp, rdata);
                end
                OP_ADC: begin
                    adc_sample(int'(e.adr), e.dat[15:0]);
                    check_mask("amp_disable", e.exp[`QLA_NUM_CHAN-1:0], amp_disable);
                end
                default: dac_passes(int'(e.dat));
            endcase
            $display("test %0d %s adr %h: %s", idx, e.op.name(), e.adr,
                     (err_count == errs_before) ? "pass" : "error");
        end

        $display("%0d tests, %0d checks, %0d errors", tbl.size(), check_count, err_count);
        if (err_count == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

    // ----------------------------------------
    // watchdog, budget from table length and DAC passes
    initial begin : watchdog
        int cycles;
        wait (table_ready);
        cycles = tbl.size() * 40;
        foreach (tbl[i]) begin
            if (tbl[i].op == OP_DAC)
                cycles += int'(tbl[i].dat) * `QLA_NUM_CHAN * FRAME_CYCLES;
        end
        repeat (cycles) @(posedge sysclk);
        $display("timeout after %0d clock periods, run stopped", cycles);
        $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
+incdir+design
design/qla_pkg.sv
design/dac_bit_timer.sv
design/dac_shifter.sv
design/dac_sequencer.sv
design/safety_check.sv
design/qla_reg_bus.sv
design/qla_motor_top.sv
bench/qla_motor_tb.sv

/* Makefile */
# Verilator build and run for the QLA motor-current path

VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = qla_motor_tb
FILELIST  = src.f
BUILD     = obj_dir
LOG       = sim.log
PASS_MSG  = Test OK

SOURCES   = $(wildcard design/*.sv design/*.svh bench/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BUILD)/V$(TOP)

$(BUILD)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

# pass only if the log holds the pass line
run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "simulation did not pass"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
